// File: Makefile
# Verilator build and run of the RV32I core testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the core and testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv -f src.f --top-module core_tb -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/Vcore_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// File: source/alu_execute.sv
// Operand select, ALU, branch compare and next pc, registered on dec_valid
`timescale 1ns/10ps

module alu_execute (
  input  logic             clk,
  input  logic             reset,
  input  logic             dec_valid_i,
  input  rv_pkg::addr_t    pc_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  rv_pkg::word_t    imm_i,
  input  rv_pkg::alu_op_t  alu_op_i,
  input  logic             a_pc_sel_i,
  input  logic             b_imm_sel_i,
  input  logic             branch_i,
  input  logic             jump_i,
  input  logic             jalr_i,
  input  logic [2:0]       funct3_i,
  input  rv_pkg::wb_sel_t  wb_sel_i,
  input  rv_pkg::word_t    rs1_data_i,
  input  rv_pkg::word_t    rs2_data_i,
  output logic             ex_valid_o,
  output rv_pkg::word_t    result_o,
  output rv_pkg::word_t    link_o,
  output rv_pkg::reg_idx_t rd_o,
  output rv_pkg::wb_sel_t  wb_sel_o,
  output rv_pkg::addr_t    pc_o,
  output rv_pkg::addr_t    next_pc_o
);

  import rv_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_res;
  addr_t pc_plus4;
  addr_t target;
  logic  br_taken;
  logic  redirect;

  assign op_a     = a_pc_sel_i ? pc_i : rs1_data_i;
  assign op_b     = b_imm_sel_i ? imm_i : rs2_data_i;
  assign pc_plus4 = pc_i + 32'd4;

  always_comb begin
    case (alu_op_i)
      ALU_ADD, ALU_ADDR: alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << op_b[4:0];
      ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> op_b[4:0];
      ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // Compare always works on the register values
  always_comb begin
    case (funct3_i)
      3'b000:  br_taken = rs1_data_i == rs2_data_i;
      3'b001:  br_taken = rs1_data_i != rs2_data_i;
      3'b100:  br_taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      3'b101:  br_taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      3'b110:  br_taken = rs1_data_i < rs2_data_i;
      3'b111:  br_taken = rs1_data_i >= rs2_data_i;
      default: br_taken = 1'b0;
    endcase
  end

  // JALR drops bit 0 of the sum
  assign target   = jalr_i ? {alu_res[31:1], 1'b0} : alu_res;
  assign redirect = jump_i || (branch_i && br_taken);

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid_i) begin
      result_o  <= alu_res;
      link_o    <= pc_plus4;
      rd_o      <= rd_i;
      wb_sel_o  <= wb_sel_i;
      pc_o      <= pc_i;
      next_pc_o <= redirect ? target : pc_plus4;
    end
  end

endmodule : alu_execute

// File: source/core_top.sv
// RV32I multi-cycle core top level, fetch to writeback wiring
`timescale 1ns/10ps

module core_top (
  input  logic             clk,
  input  logic             reset,
  output logic             imem_req_o,
  output rv_pkg::addr_t    imem_addr_o,
  input  logic             imem_ack_i,
  input  rv_pkg::word_t    imem_data_i,
  output logic             retire_o,
  output rv_pkg::addr_t    retire_pc_o,
  output rv_pkg::reg_idx_t retire_rd_o,
  output rv_pkg::word_t    retire_data_o
);

  import rv_pkg::*;

  // Fetch to decode
  logic     insn_valid;
  word_t    insn;
  addr_t    f_pc;

  // Decode outputs
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     dec_valid;
  addr_t    d_pc;
  reg_idx_t d_rd;
  word_t    d_imm;
  alu_op_t  d_alu_op;
  logic     d_a_pc_sel;
  logic     d_b_imm_sel;
  logic     d_branch;
  logic     d_jump;
  logic     d_jalr;
  logic [2:0] d_funct3;
  wb_sel_t  d_wb_sel;

  // Register file
  word_t    rs1_data;
  word_t    rs2_data;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  // Execute to writeback and fetch
  logic     ex_valid;
  word_t    e_result;
  word_t    e_link;
  reg_idx_t e_rd;
  wb_sel_t  e_wb_sel;
  addr_t    e_pc;
  addr_t    next_pc;

  fetch_unit u_fetch (
    .clk          (clk),
    .reset        (reset),
    .imem_ack_i   (imem_ack_i),
    .imem_data_i  (imem_data_i),
    .retire_i     (retire_o),
    .next_pc_i    (next_pc),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .insn_valid_o (insn_valid),
    .insn_o       (insn),
    .pc_o         (f_pc)
  );

  insn_decode u_decode (
    .clk          (clk),
    .reset        (reset),
    .insn_valid_i (insn_valid),
    .insn_i       (insn),
    .pc_i         (f_pc),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .dec_valid_o  (dec_valid),
    .pc_o         (d_pc),
    .rd_o         (d_rd),
    .imm_o        (d_imm),
    .alu_op_o     (d_alu_op),
    .a_pc_sel_o   (d_a_pc_sel),
    .b_imm_sel_o  (d_b_imm_sel),
    .branch_o     (d_branch),
    .jump_o       (d_jump),
    .jalr_o       (d_jalr),
    .funct3_o     (d_funct3),
    .wb_sel_o     (d_wb_sel)
  );

  reg_file u_regs (
    .clk        (clk),
    .reset      (reset),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  alu_execute u_execute (
    .clk         (clk),
    .reset       (reset),
    .dec_valid_i (dec_valid),
    .pc_i        (d_pc),
    .rd_i        (d_rd),
    .imm_i       (d_imm),
    .alu_op_i    (d_alu_op),
    .a_pc_sel_i  (d_a_pc_sel),
    .b_imm_sel_i (d_b_imm_sel),
    .branch_i    (d_branch),
    .jump_i      (d_jump),
    .jalr_i      (d_jalr),
    .funct3_i    (d_funct3),
    .wb_sel_i    (d_wb_sel),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .ex_valid_o  (ex_valid),
    .result_o    (e_result),
    .link_o      (e_link),
    .rd_o        (e_rd),
    .wb_sel_o    (e_wb_sel),
    .pc_o        (e_pc),
    .next_pc_o   (next_pc)
  );

  writeback u_writeback (
    .clk           (clk),
    .reset         (reset),
    .ex_valid_i    (ex_valid),
    .result_i      (e_result),
    .link_i        (e_link),
    .rd_i          (e_rd),
    .wb_sel_i      (e_wb_sel),
    .pc_i          (e_pc),
    .wr_en_o       (wr_en),
    .wr_idx_o      (wr_idx),
    .wr_data_o     (wr_data),
    .retire_o      (retire_o),
    .retire_pc_o   (retire_pc_o),
    .retire_rd_o   (retire_rd_o),
    .retire_data_o (retire_data_o)
  );

endmodule : core_top

// File: source/fetch_unit.sv
// Program counter, four-phase instruction request and instruction capture
`timescale 1ns/10ps
`include "rv_defs.svh"

module fetch_unit (
  input  logic          clk,
  input  logic          reset,
  input  logic          imem_ack_i,
  input  rv_pkg::word_t imem_data_i,
  input  logic          retire_i,
  input  rv_pkg::addr_t next_pc_i,
  output logic          imem_req_o,
  output rv_pkg::addr_t imem_addr_o,
  output logic          insn_valid_o,
  output rv_pkg::word_t insn_o,
  output rv_pkg::addr_t pc_o
);

  import rv_pkg::*;

  fetch_state_t state;
  addr_t        pc;
  word_t        insn_q;
  // Retire seen before the ack went low
  logic         retired_q;

  assign imem_addr_o = pc;
  assign pc_o        = pc;
  assign insn_o      = insn_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= IDLE;
      pc           <= `RV_RESET_PC;
      imem_req_o   <= 1'b0;
      insn_valid_o <= 1'b0;
      retired_q    <= 1'b0;
    end else begin
      insn_valid_o <= 1'b0;

      // Only one instruction in flight, so pc moves on retire alone
      if (retire_i) begin
        pc        <= next_pc_i;
        retired_q <= 1'b1;
      end

      case (state)
        IDLE: begin
          if (!imem_ack_i) begin
            state      <= REQ;
            imem_req_o <= 1'b1;
          end
        end
        REQ: begin
          // First cycle with ack high
          if (imem_ack_i) begin
            insn_q       <= imem_data_i;
            insn_valid_o <= 1'b1;
            imem_req_o   <= 1'b0;
            state        <= RELEASE;
          end
        end
        RELEASE: begin
          if (!imem_ack_i) begin
            state <= WAIT_RETIRE;
          end
        end
        WAIT_RETIRE: begin
          if (retire_i || retired_q) begin
            state      <= REQ;
            imem_req_o <= 1'b1;
            retired_q  <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address held for the whole request phase
  addr_stable_a : assert property (@(posedge clk) disable iff (reset)
    $past(imem_req_o) && imem_req_o |-> $stable(imem_addr_o));

  // Memory must have released ack before a new request
  req_after_ack_low_a : assert property (@(posedge clk) disable iff (reset)
    $rose(imem_req_o) |-> !$past(imem_ack_i));

endmodule : fetch_unit

// File: source/insn_decode.sv
// Instruction field split, immediate generation and registered control decode
`timescale 1ns/10ps
`include "rv_defs.svh"

module insn_decode (
  input  logic               clk,
  input  logic               reset,
  input  logic               insn_valid_i,
  input  rv_pkg::word_t      insn_i,
  input  rv_pkg::addr_t      pc_i,
  output rv_pkg::reg_idx_t   rs1_o,
  output rv_pkg::reg_idx_t   rs2_o,
  output logic               dec_valid_o,
  output rv_pkg::addr_t      pc_o,
  output rv_pkg::reg_idx_t   rd_o,
  output rv_pkg::word_t      imm_o,
  output rv_pkg::alu_op_t    alu_op_o,
  output logic               a_pc_sel_o,
  output logic               b_imm_sel_o,
  output logic               branch_o,
  output logic               jump_o,
  output logic               jalr_o,
  output logic [2:0]         funct3_o,
  output rv_pkg::wb_sel_t    wb_sel_o
);

  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;

  word_t      imm_d;
  alu_op_t    alu_op_d;
  alu_op_t    arith_op;
  logic       a_pc_d;
  logic       b_imm_d;
  logic       branch_d;
  logic       jump_d;
  logic       jalr_d;
  wb_sel_t    wb_sel_d;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  // Read indices straight from the held instruction
  assign rs1_o = insn_i[19:15];
  assign rs2_o = insn_i[24:20];

  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_u = {insn_i[31:12], 12'b0};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                  insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                  insn_i[30:21], 1'b0};

  // funct3 to ALU op, shared by OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  arith_op = ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    imm_d    = imm_i;
    alu_op_d = ALU_ADD;
    a_pc_d   = 1'b0;
    b_imm_d  = 1'b0;
    branch_d = 1'b0;
    jump_d   = 1'b0;
    jalr_d   = 1'b0;
    wb_sel_d = WB_NONE;
    case (opcode)
      `RV_OP_OP: begin
        // Only add has a sub variant in the register form
        alu_op_d = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : arith_op;
        wb_sel_d = WB_ALU;
      end
      `RV_OP_OP_IMM: begin
        alu_op_d = arith_op;
        b_imm_d  = 1'b1;
        wb_sel_d = WB_ALU;
      end
      `RV_OP_LUI: begin
        imm_d    = imm_u;
        alu_op_d = ALU_PASS_B;
        b_imm_d  = 1'b1;
        wb_sel_d = WB_ALU;
      end
      `RV_OP_AUIPC: begin
        imm_d    = imm_u;
        a_pc_d   = 1'b1;
        b_imm_d  = 1'b1;
        wb_sel_d = WB_ALU;
      end
      `RV_OP_BRANCH: begin
        imm_d    = imm_b;
        alu_op_d = ALU_ADDR;
        a_pc_d   = 1'b1;
        b_imm_d  = 1'b1;
        branch_d = 1'b1;
      end
      `RV_OP_JAL: begin
        imm_d    = imm_j;
        alu_op_d = ALU_ADDR;
        a_pc_d   = 1'b1;
        b_imm_d  = 1'b1;
        jump_d   = 1'b1;
        wb_sel_d = WB_LINK;
      end
      `RV_OP_JALR: begin
        alu_op_d = ALU_ADDR;
        b_imm_d  = 1'b1;
        jump_d   = 1'b1;
        jalr_d   = 1'b1;
        wb_sel_d = WB_LINK;
      end
      // Anything else retires as a no-op
      default: wb_sel_d = WB_NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= insn_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (insn_valid_i) begin
      pc_o        <= pc_i;
      rd_o        <= insn_i[11:7];
      imm_o       <= imm_d;
      alu_op_o    <= alu_op_d;
      a_pc_sel_o  <= a_pc_d;
      b_imm_sel_o <= b_imm_d;
      branch_o    <= branch_d;
      jump_o      <= jump_d;
      jalr_o      <= jalr_d;
      funct3_o    <= funct3;
      wb_sel_o    <= wb_sel_d;
    end
  end

endmodule : insn_decode

// File: source/reg_file.sv
// 32x32 integer register file, two read ports, one write port, x0 tied to zero
`timescale 1ns/10ps

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  input  logic             wr_en_i,
  input  rv_pkg::reg_idx_t wr_idx_i,
  input  rv_pkg::word_t    wr_data_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o
);

  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != '0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // x0 is never written, so it reads back zero
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule : reg_file

// File: source/rv_defs.svh
// Reset program counter and RV32I base opcode values
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Start of the instruction image
`define RV_RESET_PC   32'h01000000

// Major opcodes, insn[6:0]
`define RV_OP_OP      7'b0110011
`define RV_OP_OP_IMM  7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111

`endif

// File: source/rv_pkg.sv
// Core-wide vector types, ALU operation codes, write-back selects and fetch states
package rv_pkg;

  // Data word, also the instruction type
  typedef logic [31:0] word_t;

  // Byte address
  typedef logic [31:0] addr_t;

  // Register index
  typedef logic [4:0] reg_idx_t;

  // ALU operation
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // LUI passes the immediate straight through
  localparam alu_op_t ALU_PASS_B = 4'd10;
  // Branch and jump target adder
  localparam alu_op_t ALU_ADDR   = 4'd11;

  // Write-back source
  typedef logic [1:0] wb_sel_t;

  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_LINK = 2'd1;
  localparam wb_sel_t WB_NONE = 2'd2;

  // Instruction fetch sequencing
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RELEASE,
    WAIT_RETIRE
  } fetch_state_t;

endpackage : rv_pkg

// File: source/writeback.sv
// Result select, register file write and registered retire report
`timescale 1ns/10ps

module writeback (
  input  logic             clk,
  input  logic             reset,
  input  logic             ex_valid_i,
  input  rv_pkg::word_t    result_i,
  input  rv_pkg::word_t    link_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  rv_pkg::wb_sel_t  wb_sel_i,
  input  rv_pkg::addr_t    pc_i,
  output logic             wr_en_o,
  output rv_pkg::reg_idx_t wr_idx_o,
  output rv_pkg::word_t    wr_data_o,
  output logic             retire_o,
  output rv_pkg::addr_t    retire_pc_o,
  output rv_pkg::reg_idx_t retire_rd_o,
  output rv_pkg::word_t    retire_data_o
);

  import rv_pkg::*;

  logic writes;

  assign writes    = wb_sel_i != WB_NONE;
  assign wr_en_o   = ex_valid_i && writes;
  assign wr_idx_o  = rd_i;
  assign wr_data_o = (wb_sel_i == WB_LINK) ? link_i : result_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_o <= 1'b0;
    end else begin
      retire_o <= ex_valid_i;
    end
  end

  // Report matches what lands in the register file
  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      retire_pc_o   <= pc_i;
      retire_rd_o   <= writes ? rd_i : '0;
      retire_data_o <= (writes && rd_i != '0) ? wr_data_o : '0;
    end
  end

  // Each instruction needs a fresh fetch, so retires never touch
  retire_gap_a : assert property (@(posedge clk) disable iff (reset)
    retire_o |=> !retire_o);

endmodule : writeback

// File: src.f
+incdir+source
source/rv_pkg.sv
source/fetch_unit.sv
source/insn_decode.sv
source/reg_file.sv
source/alu_execute.sv
source/writeback.sv
source/core_top.sv
tests/core_tb.sv

// File: tests/core_tb.sv
// Core testbench with clock, reset, instruction memory responder, program, checks and watchdog
`timescale 1ns/10ps
`include "rv_defs.svh"

module core_tb;

  import rv_pkg::*;

  localparam int RESET_CYCLES   = 16;
  localparam int PROGRAM_STEPS  = 28;
  localparam int LOOP_REPEATS   = 3;
  // Worst ack delay plus pipeline and release overhead per instruction
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + (PROGRAM_STEPS + LOOP_REPEATS) * (7 + 8) + 100;

  logic     clk;
  logic     reset;
  logic     imem_req;
  addr_t    imem_addr;
  logic     imem_ack;
  word_t    imem_data;
  logic     retire;
  addr_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_data;

  word_t    imem [64];
  word_t    exp_pc [$];
  word_t    exp_rd [$];
  word_t    exp_val [$];
  logic [31:0] lfsr;

  int       fetches;
  int       retired;
  int       protocol_errors;
  int       fetch_errors;
  int       retire_errors;

  core_top uut (
    .clk           (clk),
    .reset         (reset),
    .imem_req_o    (imem_req),
    .imem_addr_o   (imem_addr),
    .imem_ack_i    (imem_ack),
    .imem_data_i   (imem_data),
    .retire_o      (retire),
    .retire_pc_o   (retire_pc),
    .retire_rd_o   (retire_rd),
    .retire_data_o (retire_data)
  );

  always #50 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int n, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  function automatic int compare_word(input string name, input word_t expected,
                                      input word_t actual);
    int mismatch;
    mismatch = (actual === expected) ? 0 : 1;
    assert (mismatch == 0) else begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
    return mismatch;
  endfunction

  // RV32I instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OP_OP};
  endfunction

  function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] opcode);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), opcode};
  endfunction

  function automatic word_t enc_u(input int imm20, input int rd, input logic [6:0] opcode);
    return {imm20[19:0], 5'(rd), opcode};
  endfunction

  function automatic word_t enc_b(input int off, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic word_t enc_j(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), `RV_OP_JAL};
  endfunction

  // Instruction on the expected path and its retire report
  task automatic program_step(input int off, input word_t insn, input int rd, input word_t val);
    imem[off / 4] = insn;
    exp_pc.push_back(`RV_RESET_PC + off);
    exp_rd.push_back(32'(rd));
    exp_val.push_back(val);
  endtask

  // Instruction that a taken branch or jump must skip
  task automatic program_skip(input int off);
    imem[off / 4] = enc_i(99, 0, 3'd0, 17, `RV_OP_OP_IMM);
  endtask

  task automatic load_program;
    for (int i = 0; i < 64; i++) begin
      imem[i] = ~(`RV_RESET_PC + 32'(i * 4));
    end
    program_step('h00, enc_u('h12345, 1, `RV_OP_LUI), 1, 32'h12345000);
    program_step('h04, enc_i(-5, 0, 3'd0, 2, `RV_OP_OP_IMM), 2, 32'hfffffffb);
    program_step('h08, enc_i(3, 0, 3'd0, 3, `RV_OP_OP_IMM), 3, 32'h3);
    program_step('h0c, enc_r(7'h20, 2, 3, 3'd0, 4), 4, 32'h8);
    program_step('h10, enc_i('h401, 2, 3'd5, 5, `RV_OP_OP_IMM), 5, 32'hfffffffd);
    program_step('h14, enc_r(7'h00, 3, 2, 3'd5, 6), 6, 32'h1fffffff);
    program_step('h18, enc_r(7'h00, 3, 2, 3'd2, 7), 7, 32'h1);
    program_step('h1c, enc_r(7'h00, 3, 2, 3'd3, 8), 8, 32'h0);
    program_step('h20, enc_i('hff, 1, 3'd4, 9, `RV_OP_OP_IMM), 9, 32'h123450ff);
    program_step('h24, enc_i('hf0, 9, 3'd7, 10, `RV_OP_OP_IMM), 10, 32'hf0);
    program_step('h28, enc_r(7'h00, 3, 10, 3'd6, 11), 11, 32'hf3);
    program_step('h2c, enc_r(7'h00, 3, 3, 3'd1, 12), 12, 32'h18);
    program_step('h30, enc_i(-4, 2, 3'd2, 13, `RV_OP_OP_IMM), 13, 32'h1);
    program_step('h34, enc_i(-1, 3, 3'd3, 14, `RV_OP_OP_IMM), 14, 32'h1);
    program_step('h38, enc_u(1, 15, `RV_OP_AUIPC), 15, 32'h01001038);
    // Write to x0, then read it back through an add
    program_step('h3c, enc_r(7'h00, 3, 3, 3'd0, 0), 0, 32'h0);
    program_step('h40, enc_r(7'h00, 3, 0, 3'd0, 16), 16, 32'h3);
    // beq taken, bne not, blt taken, bge and bltu not, bgeu taken
    program_step('h44, enc_b(8, 16, 3, 3'd0), 0, 32'h0);
    program_skip('h48);
    program_step('h4c, enc_b(8, 16, 3, 3'd1), 0, 32'h0);
    program_step('h50, enc_b(8, 3, 2, 3'd4), 0, 32'h0);
    program_skip('h54);
    program_step('h58, enc_b(8, 3, 2, 3'd5), 0, 32'h0);
    program_step('h5c, enc_b(8, 3, 2, 3'd6), 0, 32'h0);
    program_step('h60, enc_b(8, 3, 2, 3'd7), 0, 32'h0);
    program_skip('h64);
    program_step('h68, enc_j(8, 18), 18, 32'h0100006c);
    program_skip('h6c);
    program_step('h70, enc_u('h01000, 21, `RV_OP_LUI), 21, 32'h01000000);
    // Odd offset whose bit 0 is dropped from the target
    program_step('h74, enc_i('h7d, 21, 3'd0, 19, `RV_OP_JALR), 19, 32'h01000078);
    program_skip('h78);
    program_step('h7c, enc_r(7'h20, 3, 2, 3'd5, 22), 22, 32'hffffffff);
    // Final self loop
    program_step('h80, enc_j(0, 0), 0, 32'h0);
  endtask

  // Memory side of the four-phase handshake
  initial begin : responder
    logic [7:0] delay;
    word_t      off;
    int         idx;
    forever begin
      @(negedge clk);
      if (!reset && imem_req && !imem_ack) begin
        idx = (fetches < exp_pc.size()) ? fetches : exp_pc.size() - 1;
        fetch_errors += compare_word($sformatf("fetch %0d address", fetches),
                                     exp_pc[idx], imem_addr);
        random_bits(3, delay);
        repeat (delay) @(negedge clk);
        off = imem_addr - `RV_RESET_PC;
        if (off >= 32'd256 || off[1:0] != 2'b00) begin
          $display("Fetch from %h lies outside the program image", imem_addr);
          fetch_errors++;
          imem_data = '0;
        end else begin
          imem_data = imem[off[7:2]];
        end
        imem_ack = 1'b1;
        fetches++;
        while (imem_req) @(negedge clk);
        random_bits(2, delay);
        repeat (delay) @(negedge clk);
        imem_ack = 1'b0;
      end
    end
  end

  // Retire report against the expected path
  always @(negedge clk) begin
    int idx;
    if (!reset && retire) begin
      idx = (retired < exp_pc.size()) ? retired : exp_pc.size() - 1;
      retire_errors += compare_word($sformatf("retire %0d pc", retired),
                                    exp_pc[idx], retire_pc);
      retire_errors += compare_word($sformatf("retire %0d rd", retired),
                                    exp_rd[idx], word_t'(retire_rd));
      retire_errors += compare_word($sformatf("retire %0d data", retired),
                                    exp_val[idx], retire_data);
      retired++;
      retire_errors += compare_word($sformatf("handshakes at retire %0d", retired - 1),
                                    word_t'(retired), word_t'(fetches));
    end
  end

  reset_quiet_a : assert property (@(posedge clk) reset |=> !imem_req && !retire)
    else begin
      protocol_errors++;
      $display("Request or retire was high during reset or on the cycle after it");
    end

  addr_stable_a : assert property (@(posedge clk) disable iff (reset)
    imem_req && $past(imem_req) |-> $stable(imem_addr))
    else begin
      protocol_errors++;
      $display("Fetch address changed while the request was high");
    end

  req_rise_a : assert property (@(posedge clk) disable iff (reset)
    $rose(imem_req) |-> !$past(imem_ack))
    else begin
      protocol_errors++;
      $display("Request rose before ack had been seen low");
    end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 100);
    $display("Watchdog expired after %0d retires, the core stopped making progress", retired);
    $display("Test failures found");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    imem_ack        = 1'b0;
    imem_data       = '0;
    lfsr            = 32'd96454;
    fetches         = 0;
    retired         = 0;
    protocol_errors = 0;
    fetch_errors    = 0;
    retire_errors   = 0;
    load_program();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    while (retired < exp_pc.size() + LOOP_REPEATS) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("Summary: %0d retires, %0d handshakes, %0d protocol, %0d fetch, %0d retire errors",
             retired, fetches, protocol_errors, fetch_errors, retire_errors);
    if (protocol_errors + fetch_errors + retire_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : core_tb
